/* build.f */
src/htable_pkg.sv
src/cuckoo_subtable.sv
src/cuckoo_ctrl.sv
src/htable_stats.sv
src/htable_cuckoo.sv
dv/htable_cuckoo_tb.sv

/* dv/htable_cuckoo_tb.sv */
`timescale 1ns/100ps

module htable_cuckoo_tb;

    localparam int TIMEOUT_CYCLES = 300;
    // Key bits that pick a slot in some subtable
    localparam int SLOT_BITS = htable_pkg::NUM_TABLES * htable_pkg::ADDR_WID;

    logic                  clk;
    logic                  __srst;
    logic                  req;
    htable_pkg::ctrl_req_t req_data;
    logic                  rdy;
    logic                  ack;
    htable_pkg::ctrl_rsp_t rsp;
    htable_pkg::stats_t    stats;
    logic                  empty;

    // Reference model state
    htable_pkg::value_t    model [htable_pkg::key_t];
    int                    exp_insert_ok;
    int                    exp_insert_fail;
    int                    exp_delete_ok;
    int                    exp_delete_fail;
    htable_pkg::ctrl_rsp_t exp_rsp;

    integer                seed;
    logic [31:0]           rnd;
    int                    errors;
    int                    checks;
    int                    test_errors;
    int                    done_count;
    logic                  stats_due;
    logic                  timed_out;
    htable_pkg::key_t      keys [16];
    htable_pkg::key_t      chain_keys [4];

    htable_cuckoo u_htable_cuckoo (
        .clk      (clk),
        .__srst   (__srst),
        .req      (req),
        .req_data (req_data),
        .rdy      (rdy),
        .ack      (ack),
        .rsp      (rsp),
        .stats    (stats),
        .empty    (empty)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // Stored keys that share the new key's slot in every subtable
    function automatic int count_slot_rivals(input htable_pkg::key_t key);
        int n;
        n = 0;
        foreach (model[k]) begin
            if (k[SLOT_BITS-1:0] == key[SLOT_BITS-1:0]) n++;
        end
        return n;
    endfunction

    function automatic htable_pkg::ctrl_rsp_t expect_rsp(input logic [2:0] cmd,
                                                         input htable_pkg::key_t key,
                                                         input htable_pkg::value_t value);
        htable_pkg::ctrl_rsp_t r;
        r        = '0;
        r.status = htable_pkg::STATUS_OK;
        case (cmd)
            htable_pkg::CMD_NOP: begin
            end
            htable_pkg::CMD_GET: begin
                if (model.exists(key)) begin
                    r.get_valid = 1'b1;
                    r.get_value = model[key];
                end
            end
            htable_pkg::CMD_SET: begin
                if (model.exists(key)) begin
                    r.status = htable_pkg::STATUS_KEY_EXISTS;
                    exp_insert_fail++;
                end else if (count_slot_rivals(key) >= htable_pkg::NUM_TABLES) begin
                    // Every slot of the key is taken by keys that only fit there
                    r.status = htable_pkg::STATUS_INSERT_LOOP;
                    exp_insert_fail++;
                end else begin
                    model[key] = value;
                    exp_insert_ok++;
                end
            end
            htable_pkg::CMD_UNSET: begin
                if (model.exists(key)) begin
                    model.delete(key);
                    exp_delete_ok++;
                end else begin
                    r.status = htable_pkg::STATUS_KEY_NOT_FOUND;
                    exp_delete_fail++;
                end
            end
            htable_pkg::CMD_CLEAR: begin
                model.delete();
            end
            default: begin
                r.status = htable_pkg::STATUS_BAD_COMMAND;
            end
        endcase
        return r;
    endfunction

    // --------------------------------------------------
    // Checking and reporting
    // --------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic report_test(input string name);
        $display("Test %s: done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Response during ack, then counters one cycle later
    always @(negedge clk) begin
        if (stats_due) begin
            stats_due = 1'b0;
            check_val("stats.fill", 32'(stats.fill), 32'(model.num()));
            check_val("stats.insert_ok", 32'(stats.insert_ok), exp_insert_ok);
            check_val("stats.insert_fail", 32'(stats.insert_fail), exp_insert_fail);
            check_val("stats.delete_ok", 32'(stats.delete_ok), exp_delete_ok);
            check_val("stats.delete_fail", 32'(stats.delete_fail), exp_delete_fail);
            check_val("empty", 32'(empty), 32'(model.num() == 0));
            done_count++;
        end
        if (ack) begin
            check_val("rsp.status", 32'(rsp.status), 32'(exp_rsp.status));
            check_val("rsp.get_valid", 32'(rsp.get_valid), 32'(exp_rsp.get_valid));
            check_val("rsp.get_value", 32'(rsp.get_value), 32'(exp_rsp.get_value));
            stats_due = 1'b1;
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!timed_out && !rdy && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!timed_out && !rdy) begin
            $display("Timeout: rdy did not come high");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // Skipped once any wait has timed out
    task automatic do_op(input logic [2:0] cmd, input htable_pkg::key_t key,
                         input htable_pkg::value_t value);
        int waited;
        int start_count;
        wait_ready();
        if (!timed_out) begin
            exp_rsp              = expect_rsp(cmd, key, value);
            start_count          = done_count;
            req                  = 1'b1;
            req_data.command     = htable_pkg::command_e'(cmd);
            req_data.key         = key;
            req_data.value       = value;
            @(posedge clk);
            #2;
            req                  = 1'b0;
            // Busy from the cycle after acceptance
            check_val("rdy", 32'(rdy), 32'd0);
            waited               = 0;
            while (done_count == start_count && waited < TIMEOUT_CYCLES) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (done_count == start_count) begin
                $display("Timeout: no ack for command %0d on key 0x%h", cmd, key);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        seed            = 32'h806a_d594;
        clk             = 1'b0;
        __srst          = 1'b1;
        req             = 1'b0;
        req_data        = '0;
        errors          = 0;
        checks          = 0;
        test_errors     = 0;
        done_count      = 0;
        stats_due       = 1'b0;
        timed_out       = 1'b0;
        exp_insert_ok   = 0;
        exp_insert_fail = 0;
        exp_delete_ok   = 0;
        exp_delete_fail = 0;
        exp_rsp         = '0;
        repeat (8) @(posedge clk);
        #2;
        __srst = 1'b0;

        // Reset state and a lookup in an empty table
        check_val("rdy", 32'(rdy), 32'd0);
        check_val("ack", 32'(ack), 32'd0);
        @(posedge clk);
        #2;
        check_val("rdy", 32'(rdy), 32'd1);
        wait_ready();
        check_val("stats.fill", 32'(stats.fill), 32'd0);
        check_val("stats.insert_ok", 32'(stats.insert_ok), 32'd0);
        check_val("stats.insert_fail", 32'(stats.insert_fail), 32'd0);
        check_val("stats.delete_ok", 32'(stats.delete_ok), 32'd0);
        check_val("stats.delete_fail", 32'(stats.delete_fail), 32'd0);
        check_val("empty", 32'(empty), 32'd1);
        rnd = $random(seed);
        do_op(htable_pkg::CMD_GET, rnd[15:0], 16'h0000);
        report_test("reset");

        // One key per low nibble, so nothing is displaced
        for (int n = 0; n < 16; n++) begin
            rnd     = $random(seed);
            keys[n] = {rnd[15:4], 4'(n)};
        end
        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            case (rnd[5:4])
                2'd1: do_op(htable_pkg::CMD_SET, keys[rnd[3:0]], rnd[31:16]);
                2'd2: do_op(htable_pkg::CMD_UNSET, keys[rnd[3:0]], 16'h0000);
                default: do_op(htable_pkg::CMD_GET, keys[rnd[3:0]], 16'h0000);
            endcase
        end
        do_op(htable_pkg::CMD_SET, keys[0], 16'h1111);
        do_op(htable_pkg::CMD_SET, keys[0], 16'h2222);
        do_op(htable_pkg::CMD_UNSET, keys[1], 16'h0000);
        do_op(htable_pkg::CMD_UNSET, keys[1], 16'h0000);
        for (int n = 0; n < 16; n++) begin
            if (model.exists(keys[n])) do_op(htable_pkg::CMD_UNSET, keys[n], 16'h0000);
        end
        report_test("random set/get/unset");

        // Keys sharing one slot in every subtable
        chain_keys[0] = 16'h0123;
        chain_keys[1] = 16'h1123;
        chain_keys[2] = 16'h2123;
        chain_keys[3] = 16'h3123;
        for (int i = 0; i < 3; i++) begin
            do_op(htable_pkg::CMD_SET, chain_keys[i], 16'ha000 + 16'(i));
        end
        for (int i = 0; i < 3; i++) begin
            do_op(htable_pkg::CMD_GET, chain_keys[i], 16'h0000);
        end
        report_test("displacement chain");

        do_op(htable_pkg::CMD_SET, chain_keys[3], 16'ha003);
        for (int i = 0; i < 4; i++) begin
            do_op(htable_pkg::CMD_GET, chain_keys[i], 16'h0000);
        end
        report_test("insert loop");

        do_op(htable_pkg::CMD_CLEAR, 16'h0000, 16'h0000);
        for (int i = 0; i < 3; i++) begin
            do_op(htable_pkg::CMD_GET, chain_keys[i], 16'h0000);
        end
        report_test("clear");

        do_op(htable_pkg::CMD_NOP, 16'h0000, 16'h0000);
        for (int code = 5; code < 8; code++) begin
            rnd = $random(seed);
            do_op(3'(code), rnd[15:0], rnd[31:16]);
        end
        report_test("nop and bad commands");

        finish_run();
    end

endmodule : htable_cuckoo_tb

/* run.sh */
#!/usr/bin/env bash
# Build and run the hash table testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -j 0 -f build.f --top-module htable_cuckoo_tb \
    -Mdir "$OBJ_DIR" -o sim_bin
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/sim_bin" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

/* src/cuckoo_ctrl.sv */
`timescale 1ns/100ps

module cuckoo_ctrl (
    input  logic                   clk,
    input  logic                   __srst,
    input  logic                   req,
    input  htable_pkg::ctrl_req_t  req_data,
    output logic                   rdy,
    output logic                   ack,
    output htable_pkg::ctrl_rsp_t  rsp,
    output logic                   tbl_strobe [htable_pkg::NUM_TABLES],
    output htable_pkg::tbl_req_t   tbl_req,
    input  logic                   tbl_ack [htable_pkg::NUM_TABLES],
    input  htable_pkg::tbl_rsp_t   tbl_rsp [htable_pkg::NUM_TABLES],
    output htable_pkg::stats_evt_t stats_evt
);

    typedef enum logic [3:0] {
        ST_RESET,
        ST_IDLE,
        ST_CLEAR,
        ST_CLEAR_WAIT,
        ST_CHECK,
        ST_CHECK_WAIT,
        ST_DELETE,
        ST_DELETE_WAIT,
        ST_INS_GET,
        ST_INS_GET_WAIT,
        ST_INS_SET,
        ST_INS_SET_WAIT,
        ST_INS_NEXT,
        ST_DONE
    } state_e;

    localparam htable_pkg::tbl_idx_t LAST_IDX = htable_pkg::tbl_idx_t'(htable_pkg::NUM_TABLES - 1);

    state_e state;
    state_e nxt_state;

    // Request context
    htable_pkg::command_e cmd_q;
    htable_pkg::key_t     key_q;
    htable_pkg::entry_t   entry_q;
    htable_pkg::status_e  status_q;
    logic                 found_q;
    logic                 loop_q;

    // Displacement hold register
    logic               hold_valid;
    htable_pkg::entry_t hold_entry;

    htable_pkg::tbl_idx_t tbl_idx;
    logic [7:0]           ops;

    logic                 tbl_go;
    htable_pkg::command_e tbl_cmd;
    logic                 idx_reset;
    logic                 idx_inc;
    logic                 ops_inc;
    logic                 status_ld;
    htable_pkg::status_e  status_nxt;
    logic                 found_set;
    logic                 loop_set;
    logic                 done;
    logic                 accept;
    logic                 get_hit;

    logic                 ack_sel;
    htable_pkg::tbl_rsp_t rsp_sel;

    assign ack_sel = tbl_ack[tbl_idx];
    assign rsp_sel = tbl_rsp[tbl_idx];
    assign rdy     = (state == ST_IDLE);
    assign accept  = req && rdy;

    // ------------------------------------------------
    // Command FSM
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            state <= ST_RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state  = state;
        tbl_go     = 1'b0;
        tbl_cmd    = htable_pkg::CMD_NOP;
        idx_reset  = 1'b0;
        idx_inc    = 1'b0;
        ops_inc    = 1'b0;
        status_ld  = 1'b0;
        status_nxt = htable_pkg::STATUS_OK;
        found_set  = 1'b0;
        loop_set   = 1'b0;
        done       = 1'b0;
        case (state)
            ST_RESET: begin
                nxt_state = ST_IDLE;
            end
            ST_IDLE: begin
                idx_reset = 1'b1;
                if (req) begin
                    status_ld = 1'b1;
                    case (req_data.command)
                        htable_pkg::CMD_NOP: nxt_state = ST_DONE;
                        htable_pkg::CMD_CLEAR: nxt_state = ST_CLEAR;
                        htable_pkg::CMD_GET,
                        htable_pkg::CMD_SET,
                        htable_pkg::CMD_UNSET: nxt_state = ST_CHECK;
                        default: begin
                            status_nxt = htable_pkg::STATUS_BAD_COMMAND;
                            nxt_state  = ST_DONE;
                        end
                    endcase
                end
            end
            ST_CLEAR: begin
                tbl_go    = 1'b1;
                tbl_cmd   = htable_pkg::CMD_CLEAR;
                nxt_state = ST_CLEAR_WAIT;
            end
            ST_CLEAR_WAIT: begin
                if (ack_sel) begin
                    idx_inc   = 1'b1;
                    nxt_state = (tbl_idx == LAST_IDX) ? ST_DONE : ST_CLEAR;
                end
            end
            // Search every table before acting
            ST_CHECK: begin
                tbl_go    = 1'b1;
                tbl_cmd   = htable_pkg::CMD_GET;
                nxt_state = ST_CHECK_WAIT;
            end
            ST_CHECK_WAIT: begin
                if (ack_sel) begin
                    if (rsp_sel.get_valid && (rsp_sel.entry.key == key_q)) begin
                        found_set = 1'b1;
                        if (cmd_q == htable_pkg::CMD_UNSET) begin
                            nxt_state = ST_DELETE;
                        end else begin
                            status_ld  = (cmd_q == htable_pkg::CMD_SET);
                            status_nxt = htable_pkg::STATUS_KEY_EXISTS;
                            nxt_state  = ST_DONE;
                        end
                    end else if (tbl_idx != LAST_IDX) begin
                        idx_inc   = 1'b1;
                        nxt_state = ST_CHECK;
                    end else if (cmd_q == htable_pkg::CMD_SET) begin
                        idx_reset = 1'b1;
                        nxt_state = ST_INS_GET;
                    end else begin
                        status_ld  = (cmd_q == htable_pkg::CMD_UNSET);
                        status_nxt = htable_pkg::STATUS_KEY_NOT_FOUND;
                        nxt_state  = ST_DONE;
                    end
                end
            end
            // Table index still points at the hit
            ST_DELETE: begin
                tbl_go    = 1'b1;
                tbl_cmd   = htable_pkg::CMD_UNSET;
                nxt_state = ST_DELETE_WAIT;
            end
            ST_DELETE_WAIT: begin
                if (ack_sel) nxt_state = ST_DONE;
            end
            ST_INS_GET: begin
                tbl_go    = 1'b1;
                tbl_cmd   = htable_pkg::CMD_GET;
                nxt_state = ST_INS_GET_WAIT;
            end
            ST_INS_GET_WAIT: begin
                if (ack_sel) begin
                    // Original key back in the way after too many moves
                    if (rsp_sel.get_valid && (rsp_sel.entry.key == key_q) &&
                        (ops > htable_pkg::OPS_LIMIT)) begin
                        loop_set   = 1'b1;
                        status_ld  = 1'b1;
                        status_nxt = htable_pkg::STATUS_INSERT_LOOP;
                    end
                    nxt_state = ST_INS_SET;
                end
            end
            ST_INS_SET: begin
                tbl_go    = 1'b1;
                tbl_cmd   = htable_pkg::CMD_SET;
                nxt_state = ST_INS_SET_WAIT;
            end
            ST_INS_SET_WAIT: begin
                if (ack_sel) begin
                    nxt_state = (hold_valid && !loop_q) ? ST_INS_NEXT : ST_DONE;
                end
            end
            // Evicted occupant becomes the entry in hand
            ST_INS_NEXT: begin
                idx_inc   = 1'b1;
                ops_inc   = 1'b1;
                nxt_state = ST_INS_GET;
            end
            ST_DONE: begin
                done      = 1'b1;
                nxt_state = ST_IDLE;
            end
            default: begin
                nxt_state = ST_RESET;
            end
        endcase
    end

    // ------------------------------------------------
    // Request context and hold register
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q         <= req_data.command;
            key_q         <= req_data.key;
            entry_q.key   <= req_data.key;
            entry_q.value <= req_data.value;
        end else if (state == ST_INS_NEXT) begin
            entry_q <= hold_entry;
        end
        if (status_ld) status_q <= status_nxt;
    end

    always_ff @(posedge clk) begin
        if (__srst || accept) begin
            found_q <= 1'b0;
            loop_q  <= 1'b0;
        end else begin
            found_q <= found_q | found_set;
            loop_q  <= loop_q | loop_set;
        end
    end

    always_ff @(posedge clk) begin
        if (__srst || (state == ST_CLEAR)) begin
            hold_valid <= 1'b0;
        end else if (ack_sel && (cmd_q != htable_pkg::CMD_CLEAR)) begin
            hold_valid <= rsp_sel.get_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_sel && (cmd_q != htable_pkg::CMD_CLEAR)) hold_entry <= rsp_sel.entry;
    end

    // ------------------------------------------------
    // Table index and displacement count
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst || idx_reset) begin
            tbl_idx <= '0;
        end else if (idx_inc) begin
            tbl_idx <= (tbl_idx == LAST_IDX) ? '0 : tbl_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (__srst || (state == ST_IDLE)) begin
            ops <= '0;
        end else if (ops_inc) begin
            ops <= ops + 1'b1;
        end
    end

    always_comb begin
        for (int t = 0; t < htable_pkg::NUM_TABLES; t++) begin
            tbl_strobe[t] = tbl_go && (tbl_idx == htable_pkg::tbl_idx_t'(t));
        end
    end

    assign tbl_req.command = tbl_cmd;
    assign tbl_req.entry   = entry_q;

    // ------------------------------------------------
    // Response and event pulses
    // ------------------------------------------------
    assign get_hit = found_q && (cmd_q == htable_pkg::CMD_GET);

    always_ff @(posedge clk) begin
        if (__srst) begin
            ack       <= 1'b0;
            stats_evt <= '0;
        end else begin
            ack                   <= done;
            stats_evt.insert_ok   <= done && (cmd_q == htable_pkg::CMD_SET) &&
                                     (status_q == htable_pkg::STATUS_OK);
            stats_evt.insert_fail <= done && (cmd_q == htable_pkg::CMD_SET) &&
                                     (status_q != htable_pkg::STATUS_OK);
            stats_evt.delete_ok   <= done && (cmd_q == htable_pkg::CMD_UNSET) &&
                                     (status_q == htable_pkg::STATUS_OK);
            stats_evt.delete_fail <= done && (cmd_q == htable_pkg::CMD_UNSET) &&
                                     (status_q != htable_pkg::STATUS_OK);
            stats_evt.clear       <= done && (cmd_q == htable_pkg::CMD_CLEAR);
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rsp.status    <= status_q;
            rsp.get_valid <= get_hit;
            rsp.get_value <= get_hit ? hold_entry.value : '0;
        end
    end

endmodule : cuckoo_ctrl

/* src/cuckoo_subtable.sv */
`timescale 1ns/100ps

module cuckoo_subtable #(
    parameter int TABLE_ID = 0
) (
    input  logic                clk,
    input  logic                __srst,
    input  logic                req,
    input  htable_pkg::tbl_req_t tbl_req,
    output logic                ack,
    output htable_pkg::tbl_rsp_t tbl_rsp
);

    // Each table indexes by its own key nibble
    localparam int SLOT_LSB = TABLE_ID * htable_pkg::ADDR_WID;

    htable_pkg::entry_t              mem [htable_pkg::TABLE_DEPTH];
    logic [htable_pkg::TABLE_DEPTH-1:0] valid;
    logic [htable_pkg::ADDR_WID-1:0]    slot;

    assign slot = tbl_req.entry.key[SLOT_LSB +: htable_pkg::ADDR_WID];

    // ------------------------------------------------
    // Valid bits
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            valid <= '0;
        end else if (req) begin
            case (tbl_req.command)
                htable_pkg::CMD_SET: begin
                    valid[slot] <= 1'b1;
                end
                htable_pkg::CMD_UNSET: begin
                    valid[slot] <= 1'b0;
                end
                htable_pkg::CMD_CLEAR: begin
                    valid <= '0;
                end
                default: begin
                    valid <= valid;
                end
            endcase
        end
    end

    // ------------------------------------------------
    // Entry storage
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (req && (tbl_req.command == htable_pkg::CMD_SET)) begin
            mem[slot] <= tbl_req.entry;
        end
    end

    // Previous occupant comes back on every access
    always_ff @(posedge clk) begin
        if (req) begin
            tbl_rsp.get_valid <= valid[slot];
            tbl_rsp.entry     <= mem[slot];
        end
    end

    always_ff @(posedge clk) begin
        if (__srst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

endmodule : cuckoo_subtable

/* src/htable_cuckoo.sv */
`timescale 1ns/100ps

module htable_cuckoo (
    input  logic                  clk,
    input  logic                  __srst,
    input  logic                  req,
    input  htable_pkg::ctrl_req_t req_data,
    output logic                  rdy,
    output logic                  ack,
    output htable_pkg::ctrl_rsp_t rsp,
    output htable_pkg::stats_t    stats,
    output logic                  empty
);

    logic                   tbl_strobe [htable_pkg::NUM_TABLES];
    logic                   tbl_ack    [htable_pkg::NUM_TABLES];
    htable_pkg::tbl_rsp_t   tbl_rsp    [htable_pkg::NUM_TABLES];
    htable_pkg::tbl_req_t   tbl_req;
    htable_pkg::stats_evt_t stats_evt;

    // ------------------------------------------------
    // Controller
    // ------------------------------------------------
    cuckoo_ctrl u_cuckoo_ctrl (
        .clk        (clk),
        .__srst     (__srst),
        .req        (req),
        .req_data   (req_data),
        .rdy        (rdy),
        .ack        (ack),
        .rsp        (rsp),
        .tbl_strobe (tbl_strobe),
        .tbl_req    (tbl_req),
        .tbl_ack    (tbl_ack),
        .tbl_rsp    (tbl_rsp),
        .stats_evt  (stats_evt)
    );

    // ------------------------------------------------
    // Subtables, one per key nibble
    // ------------------------------------------------
    for (genvar g = 0; g < htable_pkg::NUM_TABLES; g++) begin : g_tbl
        cuckoo_subtable #(
            .TABLE_ID (g)
        ) u_cuckoo_subtable (
            .clk     (clk),
            .__srst  (__srst),
            .req     (tbl_strobe[g]),
            .tbl_req (tbl_req),
            .ack     (tbl_ack[g]),
            .tbl_rsp (tbl_rsp[g])
        );
    end

    htable_stats u_htable_stats (
        .clk       (clk),
        .__srst    (__srst),
        .stats_evt (stats_evt),
        .stats     (stats),
        .empty     (empty)
    );

endmodule : htable_cuckoo

/* src/htable_pkg.sv */
package htable_pkg;

    // ------------------------------------------------
    // Sizes
    // ------------------------------------------------
    localparam int KEY_WID     = 16;
    localparam int VALUE_WID   = 16;
    localparam int NUM_TABLES  = 3;
    localparam int ADDR_WID    = 4;
    localparam int TABLE_DEPTH = 16;
    localparam int TBL_IDX_WID = 2;
    // Displacements allowed before a returning key counts as a loop
    localparam int OPS_LIMIT   = 8;
    localparam int CNT_WID     = 16;

    typedef logic [KEY_WID-1:0]     key_t;
    typedef logic [VALUE_WID-1:0]   value_t;
    typedef logic [TBL_IDX_WID-1:0] tbl_idx_t;

    typedef struct packed {
        key_t   key;
        value_t value;
    } entry_t;

    // ------------------------------------------------
    // Commands and statuses
    // ------------------------------------------------
    typedef enum logic [2:0] {
        CMD_NOP   = 3'd0,
        CMD_GET   = 3'd1,
        CMD_SET   = 3'd2,
        CMD_UNSET = 3'd3,
        CMD_CLEAR = 3'd4
    } command_e;

    typedef enum logic [2:0] {
        STATUS_OK            = 3'd0,
        STATUS_KEY_EXISTS    = 3'd1,
        STATUS_KEY_NOT_FOUND = 3'd2,
        STATUS_INSERT_LOOP   = 3'd3,
        STATUS_BAD_COMMAND   = 3'd4
    } status_e;

    // ------------------------------------------------
    // Request and response bundles
    // ------------------------------------------------
    typedef struct packed {
        command_e command;
        key_t     key;
        value_t   value;
    } ctrl_req_t;

    typedef struct packed {
        status_e status;
        logic    get_valid;
        value_t  get_value;
    } ctrl_rsp_t;

    typedef struct packed {
        command_e command;
        entry_t   entry;
    } tbl_req_t;

    // Entry is the slot occupant seen before the access
    typedef struct packed {
        logic   get_valid;
        entry_t entry;
    } tbl_rsp_t;

    typedef struct packed {
        logic insert_ok;
        logic insert_fail;
        logic delete_ok;
        logic delete_fail;
        logic clear;
    } stats_evt_t;

    typedef struct packed {
        logic [CNT_WID-1:0] fill;
        logic [CNT_WID-1:0] insert_ok;
        logic [CNT_WID-1:0] insert_fail;
        logic [CNT_WID-1:0] delete_ok;
        logic [CNT_WID-1:0] delete_fail;
    } stats_t;

endpackage : htable_pkg

/* src/htable_stats.sv */
`timescale 1ns/100ps

module htable_stats (
    input  logic                   clk,
    input  logic                   __srst,
    input  htable_pkg::stats_evt_t stats_evt,
    output htable_pkg::stats_t     stats,
    output logic                   empty
);

    // ------------------------------------------------
    // Fill level
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst || stats_evt.clear) begin
            stats.fill <= '0;
        end else if (stats_evt.insert_ok) begin
            stats.fill <= stats.fill + 1'b1;
        end else if (stats_evt.delete_ok) begin
            stats.fill <= stats.fill - 1'b1;
        end
    end

    assign empty = (stats.fill == '0);

    // ------------------------------------------------
    // Operation counters
    // ------------------------------------------------
    // Only reset zeroes these, CLEAR leaves them
    always_ff @(posedge clk) begin
        if (__srst) begin
            stats.insert_ok   <= '0;
            stats.insert_fail <= '0;
            stats.delete_ok   <= '0;
            stats.delete_fail <= '0;
        end else begin
            if (stats_evt.insert_ok) stats.insert_ok <= stats.insert_ok + 1'b1;
            if (stats_evt.insert_fail) stats.insert_fail <= stats.insert_fail + 1'b1;
            if (stats_evt.delete_ok) stats.delete_ok <= stats.delete_ok + 1'b1;
            if (stats_evt.delete_fail) stats.delete_fail <= stats.delete_fail + 1'b1;
        end
    end

endmodule : htable_stats
